// File: common/iq_config.svh
`ifndef IQ_CONFIG_SVH
`define IQ_CONFIG_SVH

// queue geometry
`define IQ_DEPTH      16
`define IQ_IDX_W      4

// execution resources
`define IQ_NUM_FU     3
`define IQ_NUM_WAKE   4

// register file and field widths
`define IQ_PHYS_REGS  64
`define IQ_REG_W      6
`define IQ_WORD_W     32
`define IQ_ROB_W      6
`define IQ_FU_W       2

// opcodes without an rs2 dependency
`define IQ_OPC_OP_IMM 7'b0010011
`define IQ_OPC_LOAD   7'b0000011

`endif

// File: common/iq_pkg.sv
`include "iq_config.svh"

package iq_pkg;

    typedef logic [`IQ_REG_W-1:0]  phys_reg_t;
    typedef logic [`IQ_WORD_W-1:0] word_t;
    typedef logic [`IQ_ROB_W-1:0]  rob_idx_t;
    typedef logic [`IQ_FU_W-1:0]   fu_id_t;
    typedef logic [`IQ_IDX_W-1:0]  iq_idx_t;

    // renamed instruction as it leaves rename, msb first
    typedef struct packed {
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic [6:0] opcode;
        phys_reg_t  rd;
        phys_reg_t  rs1;
        word_t      rs1_val;
        phys_reg_t  rs2;
        word_t      rs2_val;
        word_t      imm;
        rob_idx_t   rob_idx;
    } dispatch_req_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t tag;
        word_t     value;
    } wake_bus_t;

    // unit number sits in the two lsbs
    typedef struct packed {
        dispatch_req_t inst;
        fu_id_t        fu;
    } iq_entry_t;

    // true when any valid result bus carries this tag
    function automatic logic wake_match(input wake_bus_t [`IQ_NUM_WAKE-1:0] wake,
                                        input phys_reg_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `IQ_NUM_WAKE; w++) begin
            if (wake[w].valid && wake[w].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // value from the matching bus, lowest bus wins
    function automatic word_t wake_value(input wake_bus_t [`IQ_NUM_WAKE-1:0] wake,
                                         input phys_reg_t tag);
        word_t val;
        val = '0;
        for (int w = `IQ_NUM_WAKE - 1; w >= 0; w--) begin
            if (wake[w].valid && wake[w].tag == tag) begin
                val = wake[w].value;
            end
        end
        return val;
    endfunction

endpackage

// File: issue_queue/dispatch_decode.sv
`timescale 1ns/1ps
`include "iq_config.svh"

module dispatch_decode
    import iq_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         dispatch_valid,
    input  dispatch_req_t                dispatch_req,
    input  wake_bus_t [`IQ_NUM_WAKE-1:0] wake,
    input  logic                         queue_full,
    output logic                         new_valid,
    output iq_entry_t                    new_entry,
    output logic                         new_rs1_ready,
    output logic                         new_rs2_ready
);

    // one bit per physical register, set means value available
    logic [`IQ_PHYS_REGS-1:0] reg_ready;

    // round-robin unit pointer
    fu_id_t fu_cnt;

    logic rs1_hit;
    logic rs2_hit;
    logic rs2_exempt;

    assign new_valid = dispatch_valid && !queue_full;

    // immediate forms and loads never read rs2
    assign rs2_exempt = (dispatch_req.opcode == `IQ_OPC_OP_IMM) ||
                        (dispatch_req.opcode == `IQ_OPC_LOAD);

    assign rs1_hit = wake_match(wake, dispatch_req.rs1);
    assign rs2_hit = wake_match(wake, dispatch_req.rs2);

    assign new_rs1_ready = reg_ready[dispatch_req.rs1] || rs1_hit;
    assign new_rs2_ready = rs2_exempt || reg_ready[dispatch_req.rs2] || rs2_hit;

    // build the entry, folding in a result that lands this cycle
    always_comb begin
        new_entry.inst = dispatch_req;
        new_entry.fu   = fu_cnt;
        if (rs1_hit) begin
            new_entry.inst.rs1_val = wake_value(wake, dispatch_req.rs1);
        end
        if (rs2_hit) begin
            new_entry.inst.rs2_val = wake_value(wake, dispatch_req.rs2);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ready <= '1;
            fu_cnt    <= '0;
        end else begin
            // wakeups first
            for (int w = 0; w < `IQ_NUM_WAKE; w++) begin
                if (wake[w].valid) begin
                    reg_ready[wake[w].tag] <= 1'b1;
                end
            end
            // then the new producer, so it overrides a stale wakeup
            if (new_valid) begin
                reg_ready[dispatch_req.rd] <= 1'b0;
                if (fu_cnt == fu_id_t'(`IQ_NUM_FU - 1)) begin
                    fu_cnt <= '0;
                end else begin
                    fu_cnt <= fu_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: issue_queue/entry_store.sv
`timescale 1ns/1ps
`include "iq_config.svh"

module entry_store
    import iq_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         new_valid,
    input  iq_entry_t                    new_entry,
    input  logic                         new_rs1_ready,
    input  logic                         new_rs2_ready,
    input  wake_bus_t [`IQ_NUM_WAKE-1:0] wake,
    input  logic [`IQ_DEPTH-1:0]         issue_grant,
    output iq_entry_t [`IQ_DEPTH-1:0]    entries,
    output logic [`IQ_DEPTH-1:0]         entry_valid,
    output logic [`IQ_DEPTH-1:0]         rs1_ready,
    output logic [`IQ_DEPTH-1:0]         rs2_ready,
    output logic                         queue_full
);

    iq_idx_t free_idx;
    logic    free_found;

    // per-entry wakeup hits this cycle
    logic [`IQ_DEPTH-1:0] rs1_wake;
    logic [`IQ_DEPTH-1:0] rs2_wake;

    // lowest free slot
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_idx   = iq_idx_t'(i);
                free_found = 1'b1;
            end
        end
    end

    assign queue_full = !free_found;

    // only waiting sources of live entries listen to the buses
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            rs1_wake[i] = entry_valid[i] && !rs1_ready[i] &&
                          wake_match(wake, entries[i].inst.rs1);
            rs2_wake[i] = entry_valid[i] && !rs2_ready[i] &&
                          wake_match(wake, entries[i].inst.rs2);
        end
    end

    // valid and ready bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid <= '0;
            rs1_ready   <= '0;
            rs2_ready   <= '0;
        end else begin
            // granted entries leave the queue on the issue edge
            entry_valid <= entry_valid & ~issue_grant;
            rs1_ready   <= rs1_ready | rs1_wake;
            rs2_ready   <= rs2_ready | rs2_wake;
            if (new_valid) begin
                entry_valid[free_idx] <= 1'b1;
                rs1_ready[free_idx]   <= new_rs1_ready;
                rs2_ready[free_idx]   <= new_rs2_ready;
            end
        end
    end

    // entry payload, operand values captured from the buses
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (rs1_wake[i]) begin
                entries[i].inst.rs1_val <= wake_value(wake, entries[i].inst.rs1);
            end
            if (rs2_wake[i]) begin
                entries[i].inst.rs2_val <= wake_value(wake, entries[i].inst.rs2);
            end
        end
        // free slot is never awake, no overlap with the capture above
        if (new_valid) begin
            entries[free_idx] <= new_entry;
        end
    end

endmodule

// File: issue_queue/issue_select.sv
`timescale 1ns/1ps
`include "iq_config.svh"

module issue_select
    import iq_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  iq_entry_t [`IQ_DEPTH-1:0]  entries,
    input  logic [`IQ_DEPTH-1:0]       entry_valid,
    input  logic [`IQ_DEPTH-1:0]       rs1_ready,
    input  logic [`IQ_DEPTH-1:0]       rs2_ready,
    output logic [`IQ_DEPTH-1:0]       issue_grant,
    output logic [`IQ_NUM_FU-1:0]      issue_valid,
    output iq_entry_t [`IQ_NUM_FU-1:0] issue_pkt
);

    // entries with both operands in hand
    logic [`IQ_DEPTH-1:0] can_issue;

    logic [`IQ_NUM_FU-1:0]            sel_found;
    iq_idx_t [`IQ_NUM_FU-1:0]         sel_idx;

    assign can_issue = entry_valid & rs1_ready & rs2_ready;

    // per unit, lowest index among its own ready entries
    always_comb begin
        issue_grant = '0;
        for (int f = 0; f < `IQ_NUM_FU; f++) begin
            sel_found[f] = 1'b0;
            sel_idx[f]   = '0;
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                if (!sel_found[f] && can_issue[i] && entries[i].fu == fu_id_t'(f)) begin
                    sel_found[f] = 1'b1;
                    sel_idx[f]   = iq_idx_t'(i);
                end
            end
            // entry belongs to one unit only, so grants never collide
            if (sel_found[f]) begin
                issue_grant[sel_idx[f]] = 1'b1;
            end
        end
    end

    // packets live for a single cycle, zero when idle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= '0;
            issue_pkt   <= '0;
        end else begin
            for (int f = 0; f < `IQ_NUM_FU; f++) begin
                issue_valid[f] <= sel_found[f];
                if (sel_found[f]) begin
                    issue_pkt[f] <= entries[sel_idx[f]];
                end else begin
                    issue_pkt[f] <= '0;
                end
            end
        end
    end

endmodule

// File: issue_queue/issue_queue_top.sv
`timescale 1ns/1ps
`include "iq_config.svh"

module issue_queue_top
    import iq_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             dispatch_valid,
    input  dispatch_req_t                    dispatch_req,
    input  wake_bus_t [`IQ_NUM_WAKE-1:0]     wake,
    output logic [`IQ_NUM_FU-1:0]            issue_valid,
    output iq_entry_t [`IQ_NUM_FU-1:0]       issue_pkt,
    output logic                             queue_full
);

    // dispatch to storage
    logic      new_valid;
    iq_entry_t new_entry;
    logic      new_rs1_ready;
    logic      new_rs2_ready;

    // storage to select
    iq_entry_t [`IQ_DEPTH-1:0] entries;
    logic [`IQ_DEPTH-1:0]      entry_valid;
    logic [`IQ_DEPTH-1:0]      rs1_ready;
    logic [`IQ_DEPTH-1:0]      rs2_ready;
    logic [`IQ_DEPTH-1:0]      issue_grant;

    dispatch_decode dispatch_decode_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_req   (dispatch_req),
        .wake           (wake),
        .queue_full     (queue_full),
        .new_valid      (new_valid),
        .new_entry      (new_entry),
        .new_rs1_ready  (new_rs1_ready),
        .new_rs2_ready  (new_rs2_ready)
    );

    entry_store entry_store_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .new_valid     (new_valid),
        .new_entry     (new_entry),
        .new_rs1_ready (new_rs1_ready),
        .new_rs2_ready (new_rs2_ready),
        .wake          (wake),
        .issue_grant   (issue_grant),
        .entries       (entries),
        .entry_valid   (entry_valid),
        .rs1_ready     (rs1_ready),
        .rs2_ready     (rs2_ready),
        .queue_full    (queue_full)
    );

    issue_select issue_select_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .entries     (entries),
        .entry_valid (entry_valid),
        .rs1_ready   (rs1_ready),
        .rs2_ready   (rs2_ready),
        .issue_grant (issue_grant),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt)
    );

endmodule

// File: bench/tb_issue_queue.sv
`timescale 1ns/1ps
`include "iq_config.svh"

module tb_issue_queue
    import iq_pkg::*;
;

    localparam int          MAX_ROWS = 64;
    localparam logic [31:0] SEED     = 32'h972f6a57;
    // plain register-register ALU opcode
    localparam logic [6:0]  OPC_OP   = 7'b0110011;

    // one cycle of stimulus and the outputs expected after its rising edge
    typedef struct packed {
        logic                            disp;
        dispatch_req_t                   req;
        wake_bus_t [`IQ_NUM_WAKE-1:0]    wake;
        logic [`IQ_NUM_FU-1:0]           exp_valid;
        logic                            exp_full;
        word_t [`IQ_NUM_FU-1:0]          exp_rs1;
        word_t [`IQ_NUM_FU-1:0]          exp_rs2;
        rob_idx_t [`IQ_NUM_FU-1:0]       exp_rob;
    } row_t;

    logic                         clk = 1'b0;
    logic                         reset_n;
    logic                         dispatch_valid;
    dispatch_req_t                dispatch_req;
    wake_bus_t [`IQ_NUM_WAKE-1:0] wake;
    logic [`IQ_NUM_FU-1:0]        issue_valid;
    iq_entry_t [`IQ_NUM_FU-1:0]   issue_pkt;
    logic                         queue_full;

    row_t          rows [MAX_ROWS];
    int            num_rows;
    logic          table_ready = 1'b0;
    // every dispatched instruction, indexed by its ROB index
    dispatch_req_t sent [64];
    rob_idx_t      next_rob;

    issue_queue_top issue_queue_top_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_req   (dispatch_req),
        .wake           (wake),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .queue_full     (queue_full)
    );

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] observed,
                         input logic [31:0] expected);
        if (observed !== expected) begin
            $display("Fail %s: observed 0x%h, expected 0x%h", name, observed, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic add_dispatch(input int r, input logic [6:0] opcode, input int rd,
                                input int rs1, input int rs2, output rob_idx_t id);
        dispatch_req_t req;
        req         = '0;
        req.opcode  = opcode;
        req.rd      = phys_reg_t'(rd);
        req.rs1     = phys_reg_t'(rs1);
        req.rs1_val = $urandom;
        req.rs2     = phys_reg_t'(rs2);
        req.rs2_val = $urandom;
        req.imm     = $urandom;
        req.rob_idx = next_rob;
        id             = next_rob;
        sent[next_rob] = req;
        next_rob       = rob_idx_t'(next_rob + 1);
        rows[r].disp = 1'b1;
        rows[r].req  = req;
    endtask

    task automatic add_wake(input int r, input int bus, input int tag, output word_t value);
        value                    = $urandom;
        rows[r].wake[bus].valid = 1'b1;
        rows[r].wake[bus].tag   = phys_reg_t'(tag);
        rows[r].wake[bus].value = value;
    endtask

    task automatic expect_issue(input int r, input int unit, input rob_idx_t id,
                                input word_t rs1_v, input word_t rs2_v);
        rows[r].exp_valid[unit] = 1'b1;
        rows[r].exp_rs1[unit]   = rs1_v;
        rows[r].exp_rs2[unit]   = rs2_v;
        rows[r].exp_rob[unit]   = id;
    endtask

    task automatic build_table();
        rob_idx_t a, b, c, d, e, f, g, h;
        rob_idx_t i1, j1, k1, l1, dropped;
        rob_idx_t fill [`IQ_DEPTH];
        word_t    v10, w11, x12, y13, z20, q21;
        for (int r = 0; r < MAX_ROWS; r++) begin
            rows[r] = '0;
        end
        next_rob = '0;
        // round-robin issue of three independent instructions
        add_dispatch(0, OPC_OP, 10, 1, 2, a);
        add_dispatch(1, OPC_OP, 11, 3, 4, b);
        add_dispatch(2, OPC_OP, 12, 5, 6, c);
        expect_issue(1, 0, a, sent[a].rs1_val, sent[a].rs2_val);
        expect_issue(2, 1, b, sent[b].rs1_val, sent[b].rs2_val);
        expect_issue(3, 2, c, sent[c].rs1_val, sent[c].rs2_val);
        // consumer of r10 waits for its wakeup
        add_dispatch(4, OPC_OP, 13, 10, 7, d);
        add_wake(6, 0, 10, v10);
        expect_issue(7, 0, d, v10, sent[d].rs2_val);
        // busy rs2 only matters for opcodes that read it
        add_dispatch(8, `IQ_OPC_OP_IMM, 14, 1, 11, e);
        add_dispatch(9, `IQ_OPC_LOAD, 15, 1, 11, f);
        add_dispatch(10, OPC_OP, 16, 1, 11, g);
        expect_issue(9, 1, e, sent[e].rs1_val, sent[e].rs2_val);
        expect_issue(10, 2, f, sent[f].rs1_val, sent[f].rs2_val);
        add_wake(12, 1, 11, w11);
        expect_issue(13, 0, g, sent[g].rs1_val, w11);
        // result lands in the dispatch cycle itself
        add_dispatch(14, OPC_OP, 17, 12, 5, h);
        add_wake(14, 2, 12, x12);
        expect_issue(15, 1, h, x12, sent[h].rs2_val);
        // fill all entries behind r13, units start at 2
        for (int k = 0; k < `IQ_DEPTH; k++) begin
            add_dispatch(16 + k, OPC_OP, 20 + k, 13, 1, fill[k]);
        end
        add_dispatch(32, OPC_OP, 36, 1, 2, dropped);
        for (int r = 31; r <= 33; r++) begin
            rows[r].exp_full = 1'b1;
        end
        add_wake(33, 3, 13, y13);
        // drain, one entry per unit and cycle in index order
        for (int j = 0; j < 6; j++) begin
            if (j < 5) begin
                expect_issue(34 + j, 0, fill[1 + 3 * j], y13, sent[fill[1 + 3 * j]].rs2_val);
                expect_issue(34 + j, 1, fill[2 + 3 * j], y13, sent[fill[2 + 3 * j]].rs2_val);
            end
            expect_issue(34 + j, 2, fill[3 * j], y13, sent[fill[3 * j]].rs2_val);
        end
        // two entries for unit 0, the dropped dispatch left the order alone
        add_dispatch(41, OPC_OP, 40, 20, 2, i1);
        add_dispatch(42, OPC_OP, 41, 21, 3, j1);
        add_dispatch(43, OPC_OP, 42, 21, 4, k1);
        add_dispatch(44, OPC_OP, 43, 20, 5, l1);
        add_wake(45, 0, 20, z20);
        expect_issue(46, 0, i1, z20, sent[i1].rs2_val);
        expect_issue(47, 0, l1, z20, sent[l1].rs2_val);
        add_wake(48, 1, 21, q21);
        expect_issue(49, 1, j1, q21, sent[j1].rs2_val);
        expect_issue(49, 2, k1, q21, sent[k1].rs2_val);
        num_rows = 51;
    endtask

    task automatic drive_row(input int r);
        dispatch_valid = rows[r].disp;
        dispatch_req   = rows[r].req;
        wake           = rows[r].wake;
    endtask

    task automatic check_row(input int r);
        string where;
        where = $sformatf("row %0d ", r);
        check({where, "queue_full"}, 32'(queue_full), 32'(rows[r].exp_full));
        check({where, "issue_valid"}, 32'(issue_valid), 32'(rows[r].exp_valid));
        for (int u = 0; u < `IQ_NUM_FU; u++) begin
            check($sformatf("%sissue_pkt[%0d].rs1_val", where, u),
                  issue_pkt[u].inst.rs1_val, rows[r].exp_rs1[u]);
            check($sformatf("%sissue_pkt[%0d].rs2_val", where, u),
                  issue_pkt[u].inst.rs2_val, rows[r].exp_rs2[u]);
            check($sformatf("%sissue_pkt[%0d].rob_idx", where, u),
                  32'(issue_pkt[u].inst.rob_idx), 32'(rows[r].exp_rob[u]));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n        = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_req   = '0;
        wake           = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        // outputs of the previous row are stable at the falling edge
        for (int r = 0; r < num_rows; r++) begin
            @(negedge clk);
            if (r > 0) begin
                check_row(r - 1);
            end
            drive_row(r);
        end
        @(negedge clk);
        check_row(num_rows - 1);
        $display("All tests passed!");
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #((num_rows + 20) * 10);
        $display("watchdog expired before the stimulus table was done");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

// File: issue_queue.f
+incdir+common
common/iq_pkg.sv
issue_queue/dispatch_decode.sv
issue_queue/entry_store.sv
issue_queue/issue_select.sv
issue_queue/issue_queue_top.sv
bench/tb_issue_queue.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_issue_queue \
    -f issue_queue.f -o sim_issue_queue
./obj_dir/sim_issue_queue > sim.log 2>&1 || true
cat sim.log
if grep -qx 'All tests passed!' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
